//--- logic/cic_bus_pkg.sv
// CIC APB bus definitions
`default_nettype none

package cic_bus_pkg;

  // Request from the APB master
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // Response back to the master
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Register map
  // Bit 0 is the filter enable
  localparam logic [7:0] ADDR_CTRL      = 8'h00;
  // Decimation ratio minus one
  localparam logic [7:0] ADDR_RATIO     = 8'h04;
  // Right shift applied before saturation
  localparam logic [7:0] ADDR_SHIFT     = 8'h08;
  // Read-only status counts
  localparam logic [7:0] ADDR_OUT_COUNT = 8'h0C;
  localparam logic [7:0] ADDR_SAT_COUNT = 8'h10;

endpackage

`default_nettype wire

//--- logic/cic_data_pkg.sv
// CIC datapath types
`default_nettype none

package cic_data_pkg;

  localparam int MAX_RATIO_BITS = 8;
  localparam int DATA_W_MAX     = 32;
  localparam int ACC_W_MAX      = 64;

  // Input sample, sign-extended from the configured input width
  typedef struct packed {
    logic                         valid;
    logic signed [DATA_W_MAX-1:0] data;
  } cic_sample_t;

  // Word passed between stages, only the low ACC_W bits are meaningful
  typedef struct packed {
    logic                        valid;
    logic signed [ACC_W_MAX-1:0] data;
  } cic_acc_t;

  // Filter output after shift and saturation
  typedef struct packed {
    logic               valid;
    logic               sat;
    logic signed [31:0] data;
  } cic_out_t;

endpackage

`default_nettype wire

//--- logic/cic_ctrl.sv
// CIC control and register file
`timescale 1ns/1ps
`default_nettype none

module cic_ctrl
  import cic_bus_pkg::*;
  import cic_data_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  apb_req_t   apb_req,
  output apb_rsp_t   apb_rsp,
  input  cic_acc_t   integ_out,
  input  cic_out_t   out_sample,
  output logic       clear,
  output logic       decim_strobe,
  output logic [5:0] shift
);

  logic                      enable;
  logic [MAX_RATIO_BITS-1:0] ratio;
  logic [MAX_RATIO_BITS-1:0] decim_count;
  logic                      group_end;
  logic [15:0]               out_count;
  logic [15:0]               sat_count;
  logic                      access;
  logic                      addr_mapped;
  logic                      addr_ro;
  logic                      wr_en;
  logic                      enable_rise;
  logic [31:0]               rd_data;

  assign access = apb_req.psel && apb_req.penable;

  // Address decode and read mux
  always_comb begin
    rd_data     = '0;
    addr_mapped = 1'b1;
    addr_ro     = 1'b0;
    case (apb_req.paddr)
      ADDR_CTRL:  rd_data = 32'(enable);
      ADDR_RATIO: rd_data = 32'(ratio);
      ADDR_SHIFT: rd_data = 32'(shift);
      ADDR_OUT_COUNT: begin
        rd_data = 32'(out_count);
        addr_ro = 1'b1;
      end
      ADDR_SAT_COUNT: begin
        rd_data = 32'(sat_count);
        addr_ro = 1'b1;
      end
      default: addr_mapped = 1'b0;
    endcase
  end

  assign apb_rsp.prdata  = rd_data;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && (!addr_mapped || (apb_req.pwrite && addr_ro));

  // Rejected writes never reach the registers
  assign wr_en       = access && apb_req.pwrite && !apb_rsp.pslverr;
  assign enable_rise = wr_en && (apb_req.paddr == ADDR_CTRL) && apb_req.pwdata[0] && !enable;

  always_ff @(posedge clk) begin
    if (reset) begin
      enable <= 1'b0;
      ratio  <= '0;
      shift  <= '0;
    end else if (wr_en) begin
      case (apb_req.paddr)
        ADDR_CTRL:  enable <= apb_req.pwdata[0];
        ADDR_RATIO: ratio  <= apb_req.pwdata[MAX_RATIO_BITS-1:0];
        ADDR_SHIFT: shift  <= apb_req.pwdata[5:0];
        default: ;
      endcase
    end
  end

  // Whole datapath is held clear while disabled
  assign clear = !enable;

  // Decimation counter advances on each integrator result
  assign group_end    = (decim_count == ratio);
  assign decim_strobe = integ_out.valid && group_end && !clear;

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      decim_count <= '0;
    end else if (integ_out.valid) begin
      decim_count <= group_end ? '0 : decim_count + 1'b1;
    end
  end

  // Status counts, restarted when the filter is enabled
  always_ff @(posedge clk) begin
    if (reset || enable_rise) begin
      out_count <= '0;
      sat_count <= '0;
    end else if (out_sample.valid) begin
      out_count <= out_count + 16'd1;
      if (out_sample.sat) begin
        sat_count <= sat_count + 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/cic_integrator_chain.sv
// CIC integrator chain
`timescale 1ns/1ps
`default_nettype none

module cic_integrator_chain
  import cic_data_pkg::*;
#(
  parameter int N     = 3,
  parameter int ACC_W = 40
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        clear,
  input  cic_sample_t in_sample,
  output cic_acc_t    integ_out
);

  logic [ACC_W-1:0] stage_in  [N];
  logic             stage_vin [N];
  logic [ACC_W-1:0] acc       [N];
  logic             acc_vld   [N];

  // Sign-extend the sample into the accumulator width
  assign stage_in[0]  = ACC_W'(in_sample.data);
  assign stage_vin[0] = in_sample.valid;

  for (genvar k = 0; k < N; k++) begin : g_stage
    if (k > 0) begin : g_link
      assign stage_in[k]  = acc[k-1];
      assign stage_vin[k] = acc_vld[k-1];
    end

    // Running sum, wraps modulo 2**ACC_W
    always_ff @(posedge clk) begin
      if (reset || clear) begin
        acc[k]     <= '0;
        acc_vld[k] <= 1'b0;
      end else begin
        acc_vld[k] <= stage_vin[k];
        if (stage_vin[k]) begin
          acc[k] <= acc[k] + stage_in[k];
        end
      end
    end
  end

  assign integ_out.valid = acc_vld[N-1];
  assign integ_out.data  = ACC_W_MAX'($signed(acc[N-1]));

endmodule

`default_nettype wire

//--- logic/cic_comb_chain.sv
// CIC comb chain
`timescale 1ns/1ps
`default_nettype none

module cic_comb_chain
  import cic_data_pkg::*;
#(
  parameter int N     = 3,
  parameter int ACC_W = 40
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     clear,
  input  cic_acc_t comb_in,
  output cic_acc_t comb_out
);

  logic [ACC_W-1:0] stage_in  [N];
  logic             stage_vin [N];
  logic [ACC_W-1:0] prev      [N];
  logic [ACC_W-1:0] diff      [N];
  logic             diff_vld  [N];

  assign stage_in[0]  = comb_in.data[ACC_W-1:0];
  assign stage_vin[0] = comb_in.valid;

  for (genvar k = 0; k < N; k++) begin : g_stage
    if (k > 0) begin : g_link
      assign stage_in[k]  = diff[k-1];
      assign stage_vin[k] = diff_vld[k-1];
    end

    // Differential delay of one decimated sample
    always_ff @(posedge clk) begin
      if (reset || clear) begin
        prev[k]     <= '0;
        diff[k]     <= '0;
        diff_vld[k] <= 1'b0;
      end else begin
        diff_vld[k] <= stage_vin[k];
        if (stage_vin[k]) begin
          diff[k] <= stage_in[k] - prev[k];
          prev[k] <= stage_in[k];
        end
      end
    end
  end

  // Only strobed words move the chain; gaps hold every stage
  assign comb_out.valid = diff_vld[N-1];
  assign comb_out.data  = ACC_W_MAX'($signed(diff[N-1]));

endmodule

`default_nettype wire

//--- logic/cic_output_stage.sv
// CIC shift and saturate stage
`timescale 1ns/1ps
`default_nettype none

module cic_output_stage
  import cic_data_pkg::*;
#(
  parameter int ACC_W = 40,
  parameter int OUT_W = 16
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       clear,
  input  cic_acc_t   comb_out,
  input  logic [5:0] shift,
  output cic_out_t   out_sample
);

  // Signed OUT_W range expressed in the accumulator width
  localparam logic signed [ACC_W-1:0] OUT_MAX = {{(ACC_W-OUT_W+1){1'b0}}, {(OUT_W-1){1'b1}}};
  localparam logic signed [ACC_W-1:0] OUT_MIN = {{(ACC_W-OUT_W+1){1'b1}}, {(OUT_W-1){1'b0}}};

  logic signed [ACC_W-1:0] acc_val;
  logic signed [ACC_W-1:0] shifted;
  logic signed [ACC_W-1:0] clamped;
  logic                    over;
  logic                    under;
  logic                    out_valid;
  logic                    out_sat;
  logic signed [31:0]      out_data;

  always_comb begin
    acc_val = comb_out.data[ACC_W-1:0];
    shifted = acc_val >>> shift;
    over    = shifted > OUT_MAX;
    under   = shifted < OUT_MIN;
    clamped = over ? OUT_MAX : (under ? OUT_MIN : shifted);
  end

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      out_valid <= 1'b0;
      out_sat   <= 1'b0;
    end else begin
      out_valid <= comb_out.valid;
      out_sat   <= comb_out.valid && (over || under);
    end
  end

  always_ff @(posedge clk) begin
    if (comb_out.valid) begin
      out_data <= 32'(clamped);
    end
  end

  assign out_sample.valid = out_valid;
  assign out_sample.sat   = out_sat;
  assign out_sample.data  = out_data;

endmodule

`default_nettype wire

//--- logic/cic_decimator.sv
// CIC decimator top level
`timescale 1ns/1ps
`default_nettype none

module cic_decimator
  import cic_bus_pkg::*;
  import cic_data_pkg::*;
#(
  parameter int N     = 3,
  parameter int IN_W  = 16,
  parameter int OUT_W = 16
) (
  input  logic        clk,
  input  logic        reset,
  input  apb_req_t    apb_req,
  output apb_rsp_t    apb_rsp,
  input  cic_sample_t in_sample,
  output cic_out_t    out_sample
);

  // Bit growth of N stages at the largest ratio
  localparam int ACC_W = IN_W + N * MAX_RATIO_BITS;

  logic       clear;
  logic       decim_strobe;
  logic [5:0] shift;
  cic_acc_t   integ_out;
  cic_acc_t   comb_in;
  cic_acc_t   comb_out;

  cic_ctrl u_cic_ctrl (
    .clk          (clk),
    .reset        (reset),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .integ_out    (integ_out),
    .out_sample   (out_sample),
    .clear        (clear),
    .decim_strobe (decim_strobe),
    .shift        (shift)
  );

  cic_integrator_chain #(.N(N), .ACC_W(ACC_W)) u_cic_integrator_chain (
    .clk       (clk),
    .reset     (reset),
    .clear     (clear),
    .in_sample (in_sample),
    .integ_out (integ_out)
  );

  // Decimated word: integrator result qualified by the strobe
  assign comb_in.valid = decim_strobe;
  assign comb_in.data  = integ_out.data;

  cic_comb_chain #(.N(N), .ACC_W(ACC_W)) u_cic_comb_chain (
    .clk      (clk),
    .reset    (reset),
    .clear    (clear),
    .comb_in  (comb_in),
    .comb_out (comb_out)
  );

  cic_output_stage #(.ACC_W(ACC_W), .OUT_W(OUT_W)) u_cic_output_stage (
    .clk        (clk),
    .reset      (reset),
    .clear      (clear),
    .comb_out   (comb_out),
    .shift      (shift),
    .out_sample (out_sample)
  );

endmodule

`default_nettype wire

//--- verif/cic_tb_model.svh
// CIC reference model and checks

// Model state wraps in the accumulator width like the filter
logic signed [ACC_W-1:0] m_integ [N];
logic signed [ACC_W-1:0] m_prev  [N];
int                      m_ratio;
int                      m_shift;
int                      m_phase;
int                      m_sats;
cic_out_t                exp_q [$];
int                      errors;
int                      checks;
logic [31:0]             lcg_state = 32'hef60_354b;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

task automatic model_reset(input int r, input int sh);
  foreach (m_integ[k]) begin
    m_integ[k] = '0;
    m_prev[k]  = '0;
  end
  m_ratio = r;
  m_shift = sh;
  m_phase = 0;
  m_sats  = 0;
  exp_q.delete();
endtask

// Integrate every sample, comb and scale every r-th one
task automatic model_push(input logic signed [IN_W-1:0] x);
  logic signed [ACC_W-1:0] v;
  logic signed [ACC_W-1:0] d;
  longint                  lim;
  cic_out_t                e;
  v = ACC_W'(x);
  foreach (m_integ[k]) begin
    m_integ[k] = m_integ[k] + v;
    v = m_integ[k];
  end
  m_phase++;
  if (m_phase == m_ratio) begin
    m_phase = 0;
    foreach (m_prev[k]) begin
      d = v - m_prev[k];
      m_prev[k] = v;
      v = d;
    end
    v = v >>> m_shift;
    // Clamp to the signed output range
    lim = 64'sd1 <<< (OUT_W - 1);
    e.valid = 1'b1;
    e.sat = (v > lim - 1) || (v < -lim);
    e.data = (v > lim - 1) ? 32'(lim - 1) : ((v < -lim) ? 32'(-lim) : 32'(v));
    m_sats += e.sat;
    exp_q.push_back(e);
  end
endtask

task automatic check_out(input cic_out_t got, input cic_out_t exp);
  checks++;
  if (got.data !== exp.data) begin
    errors++;
    $display("** Error: out_sample.data got 0x%h expected 0x%h", got.data, exp.data);
  end
  if (got.sat !== exp.sat) begin
    errors++;
    $display("** Error: out_sample.sat got 0x%h expected 0x%h", got.sat, exp.sat);
  end
endtask

task automatic check_rsp(input apb_rsp_t got, input apb_rsp_t exp, input bit with_data);
  checks++;
  if (with_data && got.prdata !== exp.prdata) begin
    errors++;
    $display("** Error: apb_rsp.prdata got 0x%h expected 0x%h", got.prdata, exp.prdata);
  end
  if (got.pslverr !== exp.pslverr) begin
    errors++;
    $display("** Error: apb_rsp.pslverr got 0x%h expected 0x%h", got.pslverr, exp.pslverr);
  end
endtask

//--- verif/cic_decimator_tb.sv
// CIC decimator testbench
`timescale 1ns/1ps
`default_nettype none

module cic_decimator_tb
  import cic_bus_pkg::*;
  import cic_data_pkg::*;
();

  localparam int N     = 3;
  localparam int IN_W  = 16;
  localparam int OUT_W = 16;
  localparam int ACC_W = IN_W + N * MAX_RATIO_BITS;

  logic                   clk;
  logic                   reset;
  apb_req_t               apb_req;
  apb_rsp_t               apb_rsp;
  cic_sample_t            in_sample;
  cic_out_t               out_sample;
  logic signed [IN_W-1:0] stim_q [$];
  cic_out_t               got_q [$];
  cic_out_t               ref_q [$];
  int                     out_seen;
  int                     test_base;
  int                     ratios [4] = '{1, 2, 5, 256};

  `include "cic_tb_model.svh"

  cic_decimator #(.N(N), .IN_W(IN_W), .OUT_W(OUT_W)) u_cic_decimator (
    .clk        (clk),
    .reset      (reset),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .in_sample  (in_sample),
    .out_sample (out_sample)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Outputs are sampled mid-cycle
  always @(negedge clk) begin
    if (!reset && out_sample.valid === 1'b1) begin
      out_seen++;
      got_q.push_back(out_sample);
      if (exp_q.size() == 0) begin
        errors++;
        $display("Output sample appeared with no model result pending");
      end else begin
        check_out(out_sample, exp_q.pop_front());
      end
    end
  end

  // Smallest shift that absorbs the r**N gain
  function automatic int gain_bits(input int r);
    longint g;
    int     s;
    g = 1;
    repeat (N) g = g * r;
    s = 0;
    while ((64'sd1 <<< s) < g) s++;
    return s;
  endfunction

  // Setup and access phases, then back to idle
  task automatic reg_access(input bit write, input logic [7:0] addr, input logic [31:0] data,
                            input bit err);
    apb_rsp_t got;
    apb_rsp_t exp;
    int       k;
    @(posedge clk);
    #1;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr,
                pwdata: write ? data : 32'h0};
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    k = 0;
    @(negedge clk);
    while (!apb_rsp.pready && k < 16) begin
      @(negedge clk);
      k++;
    end
    if (!apb_rsp.pready) begin
      errors++;
      $display("APB transfer at address 0x%h never completed", addr);
    end
    got = apb_rsp;
    exp = '{prdata: write ? 32'h0 : data, pready: 1'b1, pslverr: err};
    check_rsp(got, exp, !write && !err);
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic start_filter(input int r, input int sh);
    reg_access(1'b1, ADDR_CTRL, 32'h0, 1'b0);
    reg_access(1'b1, ADDR_RATIO, 32'(r - 1), 1'b0);
    reg_access(1'b1, ADDR_SHIFT, 32'(sh), 1'b0);
    model_reset(r, sh);
    out_seen = 0;
    got_q.delete();
    reg_access(1'b1, ADDR_CTRL, 32'h1, 1'b0);
  endtask

  task automatic make_stim(input int count, input bit full_scale);
    logic [31:0] rnd;
    stim_q.delete();
    repeat (count) begin
      rnd = lcg_next();
      if (full_scale) begin
        // Mostly positive full scale
        if (rnd[22:20] != 3'd0) begin
          stim_q.push_back({1'b0, {(IN_W-1){1'b1}}});
        end else begin
          stim_q.push_back({1'b1, {(IN_W-1){1'b0}}});
        end
      end else begin
        stim_q.push_back(rnd[31 -: IN_W]);
      end
    end
  endtask

  task automatic drive_stim(input bit gaps);
    int idle;
    foreach (stim_q[i]) begin
      idle = gaps ? int'(lcg_next() >> 30) : 0;
      repeat (idle) begin
        @(posedge clk);
        #1;
        in_sample.valid = 1'b0;
      end
      @(posedge clk);
      #1;
      in_sample.valid = 1'b1;
      in_sample.data  = DATA_W_MAX'(stim_q[i]);
      model_push(stim_q[i]);
    end
    @(posedge clk);
    #1;
    in_sample = '0;
  endtask

  task automatic wait_drain(input int r);
    int k;
    k = 0;
    while (exp_q.size() != 0 && k < 4 * (2 * N + r)) begin
      @(posedge clk);
      k++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Timed out with %0d expected output samples still missing", exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  initial begin
    int r;
    int sh;
    int n;
    apb_req   = '0;
    in_sample = '0;
    reset     = 1'b1;
    errors    = 0;
    checks    = 0;
    out_seen  = 0;
    test_base = 0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    reg_access(1'b0, ADDR_CTRL, 32'h0, 1'b0);
    reg_access(1'b0, ADDR_RATIO, 32'h0, 1'b0);
    reg_access(1'b0, ADDR_SHIFT, 32'h0, 1'b0);
    reg_access(1'b0, ADDR_SAT_COUNT, 32'h0, 1'b0);
    reg_access(1'b1, ADDR_RATIO, 32'h5a, 1'b0);
    reg_access(1'b1, ADDR_SHIFT, 32'h2b, 1'b0);
    reg_access(1'b1, 8'h20, 32'hffff_ffff, 1'b1);
    reg_access(1'b0, 8'h20, 32'h0, 1'b1);
    reg_access(1'b0, ADDR_CTRL, 32'h0, 1'b0);
    reg_access(1'b1, ADDR_OUT_COUNT, 32'h1234, 1'b1);
    reg_access(1'b0, ADDR_OUT_COUNT, 32'h0, 1'b0);
    reg_access(1'b0, ADDR_RATIO, 32'h5a, 1'b0);
    reg_access(1'b0, ADDR_SHIFT, 32'h2b, 1'b0);
    reg_access(1'b1, ADDR_CTRL, 32'h1, 1'b0);
    reg_access(1'b0, ADDR_CTRL, 32'h1, 1'b0);
    reg_access(1'b1, ADDR_CTRL, 32'h0, 1'b0);
    end_test("register access");

    foreach (ratios[i]) begin
      start_filter(ratios[i], gain_bits(ratios[i]) + int'(lcg_next() >> 30));
      make_stim(4 * ratios[i] + 7, 1'b0);
      drive_stim(1'b0);
      wait_drain(ratios[i]);
    end
    end_test("random samples");

    // Same samples with and without input gaps
    sh = gain_bits(5);
    start_filter(5, sh);
    make_stim(64, 1'b0);
    drive_stim(1'b0);
    wait_drain(5);
    ref_q = got_q;
    start_filter(5, sh);
    drive_stim(1'b1);
    wait_drain(5);
    if (got_q.size() != ref_q.size()) begin
      errors++;
      $display("Gapped input gave %0d outputs instead of %0d", got_q.size(), ref_q.size());
    end else begin
      foreach (ref_q[i]) check_out(got_q[i], ref_q[i]);
    end
    end_test("input gaps");

    start_filter(2, 0);
    make_stim(40, 1'b1);
    drive_stim(1'b0);
    wait_drain(2);
    if (m_sats == 0) begin
      errors++;
      $display("Full-scale input produced no saturated output");
    end
    reg_access(1'b0, ADDR_SAT_COUNT, 32'(m_sats), 1'b0);
    end_test("saturation");

    r = 2 + int'(lcg_next() >> 29);
    n = 30 + int'(lcg_next() >> 28);
    start_filter(r, gain_bits(r));
    make_stim(n, 1'b0);
    drive_stim(1'b0);
    wait_drain(r);
    if (out_seen != n / r) begin
      errors++;
      $display("Saw %0d outputs for %0d samples at ratio %0d", out_seen, n, r);
    end
    reg_access(1'b0, ADDR_OUT_COUNT, 32'(n / r), 1'b0);
    end_test("output count");

    // Saturate and leave a partial group in the integrators, then restart
    start_filter(3, 0);
    make_stim(20, 1'b1);
    drive_stim(1'b0);
    wait_drain(3);
    start_filter(3, gain_bits(3));
    reg_access(1'b0, ADDR_OUT_COUNT, 32'h0, 1'b0);
    reg_access(1'b0, ADDR_SAT_COUNT, 32'h0, 1'b0);
    make_stim(30, 1'b0);
    drive_stim(1'b0);
    wait_drain(3);
    reg_access(1'b0, ADDR_OUT_COUNT, 32'd10, 1'b0);
    end_test("restart");

    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+verif
logic/cic_bus_pkg.sv
logic/cic_data_pkg.sv
logic/cic_ctrl.sv
logic/cic_integrator_chain.sv
logic/cic_comb_chain.sv
logic/cic_output_stage.sv
logic/cic_decimator.sv
verif/cic_decimator_tb.sv
